//--- ta_data_pkg.sv
`default_nettype none

package ta_data_pkg;

    // ------------------------------------------------------------------------
    // Element and word geometry
    // ------------------------------------------------------------------------

    // One token or weight element
    localparam int ELEM_W = 4;

    // Elements packed into one memory word, also the projection column count
    localparam int ELEMS_PER_WORD = 8;

    localparam int WORD_W = ELEM_W * ELEMS_PER_WORD;

    // Eight 4x4 products summed, max 8 * 225 = 1800
    localparam int PROJ_W = 11;

    // Row group handled by the MAC in one cycle
    localparam int ROWS_PER_CYCLE = 4;

    // ------------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------------

    typedef logic [WORD_W-1:0] word_t;

    // Element k sits at bits [4k+3:4k] of the memory word
    typedef logic [ELEMS_PER_WORD-1:0][ELEM_W-1:0] row_t;

    typedef logic [PROJ_W-1:0] proj_t;

endpackage

`default_nettype wire

//--- ta_ctrl_pkg.sv
`default_nettype none

package ta_ctrl_pkg;

    // ------------------------------------------------------------------------
    // Sequencer phases
    // ------------------------------------------------------------------------

    typedef enum logic [2:0] {
        IDLE,
        WAIT_READY,
        LOAD_TOKENS,
        LOAD_COL,
        MAC,
        DRAIN,
        OUT
    } phase_t;

    // ------------------------------------------------------------------------
    // Length code decode
    // ------------------------------------------------------------------------

    localparam int LEN_CODE_W = 2;

    // Code 0 means 4 tokens, length is 2 ** (code + MIN_LEN_LOG2)
    localparam int MIN_LEN_LOG2 = 2;

    // Holds log2 of the length, values 2 to 5
    localparam int LEN_LOG2_W = 3;

    // Tokens at 0..L-1, weight columns right after, up to 40 words
    localparam int ADDR_W = 6;

endpackage

`default_nettype wire

//--- ta_sequencer.sv
`default_nettype none
`timescale 1ns/1ps

module ta_sequencer #(
    parameter int MAX_LEN = 32
) (
    input  wire                                          clk,
    input  wire                                          rst_n,
    input  wire                                          i_valid,
    input  wire [ta_ctrl_pkg::LEN_CODE_W-1:0]            i_length,
    input  wire                                          i_mem_ready,
    input  wire                                          i_out_done,
    output logic                                         o_mem_read,
    output logic [ta_ctrl_pkg::ADDR_W-1:0]               o_mem_addr,
    output logic                                         o_tok_wr,
    output logic [$clog2(MAX_LEN)-1:0]                   o_wr_row,
    output logic                                         o_col_load,
    output logic                                         o_mac_en,
    output logic [$clog2(MAX_LEN)-1:0]                   o_group_row,
    output logic [$clog2(ta_data_pkg::ELEMS_PER_WORD)-1:0] o_col_idx,
    output logic [ta_ctrl_pkg::LEN_LOG2_W-1:0]           o_len_log2,
    output logic                                         o_out_start
);

    localparam int ROW_W = $clog2(MAX_LEN);
    localparam int COL_W = $clog2(ta_data_pkg::ELEMS_PER_WORD);
    localparam int ADDR_W = ta_ctrl_pkg::ADDR_W;
    localparam int LOG_W = ta_ctrl_pkg::LEN_LOG2_W;

    ta_ctrl_pkg::phase_t   phase;
    ta_ctrl_pkg::phase_t   phase_nxt;
    logic [LOG_W-1:0]      len_log2;
    logic [ADDR_W-1:0]     len;
    logic [ADDR_W-1:0]     addr;
    logic [ROW_W-1:0]      group_row;
    logic [COL_W-1:0]      col_idx;
    logic                  last_group;
    logic                  last_col;
    logic                  rd_dly;
    logic                  rd_col;
    logic                  drain_cnt;

    assign len = ADDR_W'(1) << len_log2;
    assign last_group = group_row == ROW_W'(len - ADDR_W'(ta_data_pkg::ROWS_PER_CYCLE));
    assign last_col = col_idx == COL_W'(ta_data_pkg::ELEMS_PER_WORD - 1);

    // Delayed read strobe lines up with the returning memory word
    assign o_col_load = rd_dly & rd_col;
    assign o_tok_wr = rd_dly & ~rd_col;

    // LOAD_COL spends one cycle reading and one waiting for the word
    assign o_mem_read = (phase == ta_ctrl_pkg::LOAD_TOKENS) ||
                        (phase == ta_ctrl_pkg::LOAD_COL && !o_col_load);
    assign o_mem_addr = addr;
    assign o_mac_en = phase == ta_ctrl_pkg::MAC;
    assign o_group_row = group_row;
    assign o_col_idx = col_idx;
    assign o_len_log2 = len_log2;
    assign o_out_start = (phase == ta_ctrl_pkg::DRAIN) && drain_cnt;

    // ------------------------------------------------------------------------
    // Phase FSM
    // ------------------------------------------------------------------------

    always_comb begin
        phase_nxt = phase;
        case (phase)
            ta_ctrl_pkg::IDLE: begin
                if (i_valid)
                    phase_nxt = ta_ctrl_pkg::WAIT_READY;
            end
            ta_ctrl_pkg::WAIT_READY: begin
                if (i_mem_ready)
                    phase_nxt = ta_ctrl_pkg::LOAD_TOKENS;
            end
            ta_ctrl_pkg::LOAD_TOKENS: begin
                if (addr == len - ADDR_W'(1))
                    phase_nxt = ta_ctrl_pkg::LOAD_COL;
            end
            ta_ctrl_pkg::LOAD_COL: begin
                if (o_col_load)
                    phase_nxt = ta_ctrl_pkg::MAC;
            end
            ta_ctrl_pkg::MAC: begin
                if (last_group)
                    phase_nxt = last_col ? ta_ctrl_pkg::DRAIN : ta_ctrl_pkg::LOAD_COL;
            end
            // Products, then sums, must land before streaming
            ta_ctrl_pkg::DRAIN: begin
                if (drain_cnt)
                    phase_nxt = ta_ctrl_pkg::OUT;
            end
            ta_ctrl_pkg::OUT: begin
                if (i_out_done)
                    phase_nxt = ta_ctrl_pkg::IDLE;
            end
            default: phase_nxt = ta_ctrl_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= ta_ctrl_pkg::IDLE;
            len_log2 <= '0;
            addr <= '0;
            group_row <= '0;
            col_idx <= '0;
            rd_dly <= 1'b0;
            rd_col <= 1'b0;
            drain_cnt <= 1'b0;
        end else begin
            phase <= phase_nxt;
            rd_dly <= o_mem_read;
            rd_col <= phase == ta_ctrl_pkg::LOAD_COL;
            drain_cnt <= (phase == ta_ctrl_pkg::DRAIN) && !drain_cnt;

            if (phase == ta_ctrl_pkg::IDLE) begin
                addr <= '0;
                group_row <= '0;
                col_idx <= '0;
                if (i_valid)
                    len_log2 <= LOG_W'(i_length) + LOG_W'(ta_ctrl_pkg::MIN_LEN_LOG2);
            end

            // One counter walks tokens, then weight columns at L+j
            if (o_mem_read)
                addr <= addr + 1'b1;

            if (o_mac_en) begin
                if (last_group) begin
                    group_row <= '0;
                    col_idx <= col_idx + 1'b1;
                end else begin
                    group_row <= group_row + ROW_W'(ta_data_pkg::ROWS_PER_CYCLE);
                end
            end
        end
    end

    // Row of the word now arriving from memory
    always_ff @(posedge clk) begin
        o_wr_row <= addr[ROW_W-1:0];
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    a_done_in_out: assert property (@(posedge clk) disable iff (!rst_n)
        i_out_done |-> phase == ta_ctrl_pkg::OUT);

    a_addr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        o_mem_read |-> o_mem_addr < len + ADDR_W'(ta_data_pkg::ELEMS_PER_WORD));

endmodule

`default_nettype wire

//--- ta_token_store.sv
`default_nettype none
`timescale 1ns/1ps

module ta_token_store #(
    parameter int MAX_LEN = 32
) (
    input  wire                                              clk,
    input  wire                                              rst_n,
    input  wire                                              i_tok_wr,
    input  wire [$clog2(MAX_LEN)-1:0]                        i_wr_row,
    input  wire ta_data_pkg::word_t                          i_mem_data,
    input  wire [$clog2(MAX_LEN)-1:0]                        i_rd_row,
    output ta_data_pkg::row_t [ta_data_pkg::ROWS_PER_CYCLE-1:0] o_rows
);

    localparam int ROW_W = $clog2(MAX_LEN);
    localparam int ELEM_W = ta_data_pkg::ELEM_W;
    localparam int NELEM = ta_data_pkg::ELEMS_PER_WORD;
    localparam int AVG_SH = $clog2(NELEM);
    localparam int SUM_W = ELEM_W + AVG_SH;

    ta_data_pkg::row_t     mem [MAX_LEN];
    ta_data_pkg::row_t     in_row;
    ta_data_pkg::row_t     thr_row;
    logic [SUM_W-1:0]      row_sum;
    logic [ELEM_W-1:0]     row_avg;

    // ------------------------------------------------------------------------
    // Row-average threshold
    // ------------------------------------------------------------------------

    always_comb begin
        in_row = i_mem_data;
        row_sum = '0;
        for (int k = 0; k < NELEM; k++)
            row_sum = row_sum + SUM_W'(in_row[k]);
        // Divide by eight
        row_avg = row_sum[AVG_SH +: ELEM_W];
        for (int k = 0; k < NELEM; k++)
            thr_row[k] = (in_row[k] < row_avg) ? '0 : in_row[k];
    end

    always_ff @(posedge clk) begin
        if (i_tok_wr)
            mem[i_wr_row] <= thr_row;
    end

    // Group read of rows i_rd_row to i_rd_row+3
    always_comb begin
        for (int g = 0; g < ta_data_pkg::ROWS_PER_CYCLE; g++)
            o_rows[g] = mem[i_rd_row + ROW_W'(g)];
    end

    a_rd_group_range: assert property (@(posedge clk) disable iff (!rst_n)
        int'(i_rd_row) + ta_data_pkg::ROWS_PER_CYCLE <= MAX_LEN);

endmodule

`default_nettype wire

//--- ta_proj_mac.sv
`default_nettype none
`timescale 1ns/1ps

module ta_proj_mac #(
    parameter int ROW_W = 5
) (
    input  wire                                                clk,
    input  wire                                                rst_n,
    input  wire                                                i_col_load,
    input  wire ta_data_pkg::word_t                            i_mem_data,
    input  wire                                                i_mac_en,
    input  wire ta_data_pkg::row_t [ta_data_pkg::ROWS_PER_CYCLE-1:0] i_rows,
    input  wire [ROW_W-1:0]                                    i_group_row,
    input  wire [$clog2(ta_data_pkg::ELEMS_PER_WORD)-1:0]      i_col_idx,
    output logic                                               o_sum_valid,
    output ta_data_pkg::proj_t [ta_data_pkg::ROWS_PER_CYCLE-1:0] o_sums,
    output logic [ROW_W-1:0]                                   o_sum_row,
    output logic [$clog2(ta_data_pkg::ELEMS_PER_WORD)-1:0]     o_sum_col
);

    localparam int COL_W = $clog2(ta_data_pkg::ELEMS_PER_WORD);
    localparam int GRP = ta_data_pkg::ROWS_PER_CYCLE;
    localparam int NELEM = ta_data_pkg::ELEMS_PER_WORD;
    localparam int PROD_W = 2 * ta_data_pkg::ELEM_W;

    ta_data_pkg::row_t              col;
    logic [PROD_W-1:0]              prod [GRP][NELEM];
    logic                           prod_valid;
    logic [ROW_W-1:0]               prod_row;
    logic [COL_W-1:0]               prod_col;
    ta_data_pkg::proj_t [GRP-1:0]   sum_nxt;

    // ------------------------------------------------------------------------
    // Stage 1: weight column latch and 32 products
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (i_col_load)
            col <= i_mem_data;
        if (i_mac_en) begin
            for (int r = 0; r < GRP; r++) begin
                for (int k = 0; k < NELEM; k++)
                    prod[r][k] <= PROD_W'(i_rows[r][k]) * PROD_W'(col[k]);
            end
            prod_row <= i_group_row;
            prod_col <= i_col_idx;
        end
    end

    // ------------------------------------------------------------------------
    // Stage 2: one eight-term sum per row
    // ------------------------------------------------------------------------

    always_comb begin
        for (int r = 0; r < GRP; r++) begin
            sum_nxt[r] = '0;
            for (int k = 0; k < NELEM; k++)
                sum_nxt[r] = sum_nxt[r] + ta_data_pkg::PROJ_W'(prod[r][k]);
        end
    end

    always_ff @(posedge clk) begin
        if (prod_valid) begin
            o_sums <= sum_nxt;
            o_sum_row <= prod_row;
            o_sum_col <= prod_col;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
            o_sum_valid <= 1'b0;
        end else begin
            prod_valid <= i_mac_en;
            o_sum_valid <= prod_valid;
        end
    end

endmodule

`default_nettype wire

//--- ta_proj_out.sv
`default_nettype none
`timescale 1ns/1ps

module ta_proj_out #(
    parameter int MAX_LEN = 32
) (
    input  wire                                                clk,
    input  wire                                                rst_n,
    input  wire                                                i_sum_valid,
    input  wire ta_data_pkg::proj_t [ta_data_pkg::ROWS_PER_CYCLE-1:0] i_sums,
    input  wire [$clog2(MAX_LEN)-1:0]                          i_sum_row,
    input  wire [$clog2(ta_data_pkg::ELEMS_PER_WORD)-1:0]      i_sum_col,
    input  wire                                                i_out_start,
    input  wire [ta_ctrl_pkg::LEN_LOG2_W-1:0]                  i_len_log2,
    output logic                                               o_valid,
    output ta_data_pkg::proj_t                                 o_data,
    output logic                                               o_out_done
);

    localparam int ROW_W = $clog2(MAX_LEN);
    localparam int COL_W = $clog2(ta_data_pkg::ELEMS_PER_WORD);
    localparam int IDX_W = ROW_W + COL_W;

    ta_data_pkg::proj_t    pmat [MAX_LEN * ta_data_pkg::ELEMS_PER_WORD];
    logic [IDX_W-1:0]      rd_idx;
    logic [ROW_W-1:0]      last_row;

    // Index is {row, col}, so a linear count is row-major order
    always_ff @(posedge clk) begin
        if (i_sum_valid) begin
            for (int g = 0; g < ta_data_pkg::ROWS_PER_CYCLE; g++)
                pmat[{i_sum_row + ROW_W'(g), i_sum_col}] <= i_sums[g];
        end
    end

    // L-1 as a mask of the low len_log2 bits
    assign last_row = ~({ROW_W{1'b1}} << i_len_log2);
    assign o_out_done = o_valid && (rd_idx == {last_row, {COL_W{1'b1}}});
    assign o_data = pmat[rd_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_valid <= 1'b0;
            rd_idx <= '0;
        end else if (i_out_start) begin
            o_valid <= 1'b1;
            rd_idx <= '0;
        end else if (o_valid) begin
            rd_idx <= rd_idx + 1'b1;
            if (o_out_done)
                o_valid <= 1'b0;
        end
    end

    a_no_write_while_out: assert property (@(posedge clk) disable iff (!rst_n)
        !(o_valid && i_sum_valid));

endmodule

`default_nettype wire

//--- ta_top.sv
`default_nettype none
`timescale 1ns/1ps

module ta_top #(
    parameter int MAX_LEN = 32
) (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire                                   i_valid,
    input  wire [ta_ctrl_pkg::LEN_CODE_W-1:0]     i_length,
    input  wire                                   i_mem_ready,
    input  wire ta_data_pkg::word_t               i_mem_data,
    output logic                                  o_mem_read,
    output logic [ta_ctrl_pkg::ADDR_W-1:0]        o_mem_addr,
    output logic                                  o_valid,
    output ta_data_pkg::proj_t                    o_data
);

    localparam int ROW_W = $clog2(MAX_LEN);
    localparam int COL_W = $clog2(ta_data_pkg::ELEMS_PER_WORD);
    localparam int GRP = ta_data_pkg::ROWS_PER_CYCLE;

    logic                                  tok_wr;
    logic [ROW_W-1:0]                      wr_row;
    logic                                  col_load;
    logic                                  mac_en;
    logic [ROW_W-1:0]                      group_row;
    logic [COL_W-1:0]                      col_idx;
    logic [ta_ctrl_pkg::LEN_LOG2_W-1:0]    len_log2;
    logic                                  out_start;
    logic                                  out_done;
    ta_data_pkg::row_t [GRP-1:0]           rows;
    logic                                  sum_valid;
    ta_data_pkg::proj_t [GRP-1:0]          sums;
    logic [ROW_W-1:0]                      sum_row;
    logic [COL_W-1:0]                      sum_col;

    ta_sequencer #(
        .MAX_LEN (MAX_LEN)
    ) u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_valid     (i_valid),
        .i_length    (i_length),
        .i_mem_ready (i_mem_ready),
        .i_out_done  (out_done),
        .o_mem_read  (o_mem_read),
        .o_mem_addr  (o_mem_addr),
        .o_tok_wr    (tok_wr),
        .o_wr_row    (wr_row),
        .o_col_load  (col_load),
        .o_mac_en    (mac_en),
        .o_group_row (group_row),
        .o_col_idx   (col_idx),
        .o_len_log2  (len_log2),
        .o_out_start (out_start)
    );

    ta_token_store #(
        .MAX_LEN (MAX_LEN)
    ) u_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_tok_wr   (tok_wr),
        .i_wr_row   (wr_row),
        .i_mem_data (i_mem_data),
        .i_rd_row   (group_row),
        .o_rows     (rows)
    );

    ta_proj_mac #(
        .ROW_W (ROW_W)
    ) u_mac (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_col_load  (col_load),
        .i_mem_data  (i_mem_data),
        .i_mac_en    (mac_en),
        .i_rows      (rows),
        .i_group_row (group_row),
        .i_col_idx   (col_idx),
        .o_sum_valid (sum_valid),
        .o_sums      (sums),
        .o_sum_row   (sum_row),
        .o_sum_col   (sum_col)
    );

    ta_proj_out #(
        .MAX_LEN (MAX_LEN)
    ) u_out (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_sum_valid (sum_valid),
        .i_sums      (sums),
        .i_sum_row   (sum_row),
        .i_sum_col   (sum_col),
        .i_out_start (out_start),
        .i_len_log2  (len_log2),
        .o_valid     (o_valid),
        .o_data      (o_data),
        .o_out_done  (out_done)
    );

endmodule

`default_nettype wire

//--- tb_ta.sv
`default_nettype none
`timescale 1ns/1ps

module tb_ta;

    localparam int MAX_TESTS = 8;
    localparam int BUF_WORDS = 512;
    localparam int NCOL = 8;
    localparam int RESET_CYCLES = 16;

    logic                clk;
    logic                rst_n;
    logic                i_valid;
    logic [1:0]          i_length;
    logic                i_mem_ready;
    logic [31:0]         i_mem_data = 32'h0;
    logic                o_mem_read;
    logic [5:0]          o_mem_addr;
    logic                o_valid;
    logic [10:0]         o_data;

    // Tests as read from the stimulus file
    int                  num_tests;
    logic [127:0]        test_name [MAX_TESTS];
    int                  test_code [MAX_TESTS];
    int                  test_sum [MAX_TESTS];
    int                  test_off [MAX_TESTS];
    logic [31:0]         word_buf [BUF_WORDS];

    logic [31:0]         mem_img [64];
    int                  exp_p [256];
    int                  got_q [$];
    string               cur_test;
    int                  checks;
    int                  errors;
    int                  limit_cycles;
    int                  rd_count;
    logic                rd_pend = 1'b0;
    logic [31:0]         rd_word = 32'h0;

    ta_top #(
        .MAX_LEN (32)
    ) dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_valid     (i_valid),
        .i_length    (i_length),
        .i_mem_ready (i_mem_ready),
        .i_mem_data  (i_mem_data),
        .o_mem_read  (o_mem_read),
        .o_mem_addr  (o_mem_addr),
        .o_valid     (o_valid),
        .o_data      (o_data)
    );

    always #50 clk = ~clk;

    // ------------------------------------------------------------------------
    // Memory model and output capture
    // ------------------------------------------------------------------------

    // Read seen mid-cycle and its word driven just after the next edge
    always @(negedge clk) begin
        rd_pend = o_mem_read;
        rd_word = mem_img[o_mem_addr];
        // Tokens then weight columns, one address after the other
        if (rst_n && o_mem_read) begin
            compare_value("o_mem_addr", rd_count, int'(o_mem_addr));
            rd_count++;
        end
    end

    always @(posedge clk) begin
        #1;
        i_mem_data = rd_pend ? rd_word : 32'h0;
    end

    always @(negedge clk) begin
        if (rst_n && o_valid)
            got_q.push_back(int'(o_data));
    end

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------

    function automatic logic [31:0] threshold_row(input logic [31:0] w);
        int sum;
        int avg;
        logic [31:0] r;
        sum = 0;
        for (int k = 0; k < 8; k++)
            sum += int'(w[4*k +: 4]);
        avg = sum / 8;
        r = w;
        for (int k = 0; k < 8; k++) begin
            if (int'(w[4*k +: 4]) < avg)
                r[4*k +: 4] = 4'h0;
        end
        return r;
    endfunction

    // P[r][c] is thresholded row r dotted with weight column c
    function automatic void build_expected(input int len);
        logic [31:0] tr;
        logic [31:0] wc;
        int acc;
        for (int r = 0; r < len; r++) begin
            tr = threshold_row(mem_img[r]);
            for (int c = 0; c < NCOL; c++) begin
                wc = mem_img[len + c];
                acc = 0;
                for (int k = 0; k < 8; k++)
                    acc += int'(tr[4*k +: 4]) * int'(wc[4*k +: 4]);
                exp_p[r * NCOL + c] = acc;
            end
        end
    endfunction

    task automatic compare_value(input string what, input int expected, input int actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s: %s expected %0d actual %0d", cur_test, what, expected, actual);
        end
    endtask

    task automatic load_stimulus(output bit ok);
        int fd;
        int n;
        int code;
        int csum;
        int len;
        int next_off;
        bit more;
        logic [127:0] nm;
        logic [31:0] w;
        logic [8*160-1:0] line;
        ok = 1'b0;
        num_tests = 0;
        next_off = 0;
        fd = $fopen("ta_stimulus.txt", "r");
        if (fd != 0) begin
            // Skip the two column description lines
            n = $fgets(line, fd);
            n = $fgets(line, fd);
            more = 1'b1;
            while (more && num_tests < MAX_TESTS) begin
                n = $fscanf(fd, "%s %d %d", nm, code, csum);
                if (n != 3) begin
                    more = 1'b0;
                end else begin
                    len = 1 << (code + 2);
                    test_name[num_tests] = nm;
                    test_code[num_tests] = code;
                    test_sum[num_tests] = csum;
                    test_off[num_tests] = next_off;
                    for (int i = 0; i < len + NCOL; i++) begin
                        n = $fscanf(fd, "%h", w);
                        word_buf[next_off + i] = w;
                    end
                    next_off += len + NCOL;
                    num_tests++;
                end
            end
            $fclose(fd);
            ok = num_tests > 0;
        end
    endtask

    // ------------------------------------------------------------------------
    // One run that starts and ends just after a rising edge
    // ------------------------------------------------------------------------

    task automatic run_test(input int t);
        int len;
        int total;
        int delay;
        int sum;
        logic [1:0] code;
        logic [1:0] other_code;
        code = 2'(test_code[t]);
        other_code = code + 2'd1;
        len = 1 << (test_code[t] + 2);
        total = len * NCOL;
        cur_test = $sformatf("%0s", test_name[t]);
        for (int i = 0; i < len + NCOL; i++)
            mem_img[i] = word_buf[test_off[t] + i];
        build_expected(len);
        got_q.delete();
        rd_count = 0;
        delay = int'($urandom % 8);

        i_valid = 1'b1;
        i_length = code;
        i_mem_ready = (delay == 0);
        @(posedge clk);
        #1;
        i_valid = 1'b0;
        for (int i = 1; i < delay; i++) begin
            @(posedge clk);
            #1;
        end
        i_mem_ready = 1'b1;
        repeat (2) begin
            @(posedge clk);
            #1;
        end

        // Start pulse with another length while busy
        i_valid = 1'b1;
        i_length = other_code;
        @(posedge clk);
        #1;
        i_valid = 1'b0;
        i_length = code;

        while (got_q.size() < total)
            @(posedge clk);
        #1;
        compare_value("o_valid low after last output", 0, int'(o_valid));
        compare_value("memory reads", len + NCOL, rd_count);
        sum = 0;
        for (int i = 0; i < total; i++) begin
            compare_value($sformatf("P[%0d][%0d]", i / NCOL, i % NCOL), exp_p[i], got_q[i]);
            sum += got_q[i];
        end
        compare_value("checksum", test_sum[t], sum);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------------------

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", limit_cycles);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        bit ok;
        clk = 1'b0;
        rst_n = 1'b0;
        i_valid = 1'b0;
        i_length = 2'd0;
        i_mem_ready = 1'b0;
        checks = 0;
        errors = 0;
        rd_count = 0;
        limit_cycles = 0;
        cur_test = "reset";
        void'($urandom(32'h8a4e));
        load_stimulus(ok);
        if (!ok) begin
            $display("Could not read any test from ta_stimulus.txt");
            $display("TEST FAIL");
            $finish;
        end else begin
            limit_cycles = RESET_CYCLES;
            for (int t = 0; t < num_tests; t++)
                limit_cycles += (1 << (test_code[t] + 2)) * 20 + 200;
            repeat (RESET_CYCLES) @(posedge clk);
            #1;
            rst_n = 1'b1;

            // Quiet until the first start pulse
            repeat (4) begin
                @(negedge clk);
                compare_value("o_valid while idle", 0, int'(o_valid));
                compare_value("o_mem_read while idle", 0, int'(o_mem_read));
            end
            @(posedge clk);
            #1;

            // Each run starts right after the previous one's last output
            for (int t = 0; t < num_tests; t++)
                run_test(t);

            cur_test = "tail";
            repeat (20) begin
                @(negedge clk);
                compare_value("o_valid after last run", 0, int'(o_valid));
            end

            $display("Checks: %0d, errors: %0d", checks, errors);
            if (errors == 0)
                $display("TEST PASS");
            else
                $display("TEST FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- ta_stimulus.txt
# name length_code checksum (decimal), then L token words and 8 weight words (hex)
# each word holds eight 4-bit elements, element 0 in the low nibble
thresh_len4 0 7770
F1F1F1F1 0000000F 88888888 1234ABCD
12345678 87654321 11111111 22222222 F0F0F0F0 0F0F0F0F 00000000 FFFFFFFF
len8 1 10206
11111111 22222222 01234567 76543210 FFFFFFFF 00000000 90000000 55AA55AA
FFFFFFFF 11111111 12345678 0F0F0F0F 22222222 87654321 F0F0F0F0 00000000
len16 2 25158
33333333 44444444 F0000000 0F0F0F0F 12121212 EEEE1111 66666666 77777777
A5A5A5A5 00000001 99999999 13579BDF C3C3C3C3 22222222 BBBB0000 8421F000
87654321 F0F0F0F0 FFFFFFFF 00000000 12345678 22222222 0F0F0F0F 11111111
len32 3 52668
11111111 22222222 01234567 76543210 FFFFFFFF 00000000 90000000 55AA55AA
DDDDDDDD 10000000 FEDCBA98 00FF00FF 31313131 AAAAAAAA 0000FFFF 12345678
33333333 44444444 F0000000 0F0F0F0F 12121212 EEEE1111 66666666 77777777
A5A5A5A5 00000001 99999999 13579BDF C3C3C3C3 22222222 BBBB0000 8421F000
0F0F0F0F 00000000 22222222 FFFFFFFF 11111111 12345678 87654321 F0F0F0F0

//--- src.f
ta_data_pkg.sv
ta_ctrl_pkg.sv
ta_sequencer.sv
ta_token_store.sv
ta_proj_mac.sv
ta_proj_out.sv
ta_top.sv
tb_ta.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_ta -f src.f -o tb_ta

out=$(./obj_dir/tb_ta)
echo "$out"

# Fails the script unless the pass line was printed
echo "$out" | grep -qx "TEST PASS"
